//--- ooo_testdata.txt
// columns: instruction word, expected commit rd, expected commit value (all hex)
// an all-zero instruction is a nop and has no commit
00500093 01 00000005  // addi x1, x0, 5
FFD00113 02 FFFFFFFD  // addi x2, x0, -3
123451B7 03 12345000  // lui x3, 0x12345
00000000 00 00000000  // nop
00208233 04 00000002  // add x4, x1, x2
402082B3 05 00000008  // sub x5, x1, x2
0020F333 06 00000005  // and x6, x1, x2
0030E3B3 07 12345005  // or x7, x1, x3
00114433 08 FFFFFFF8  // xor x8, x2, x1
001124B3 09 00000001  // slt x9, x2, x1
00109533 0A 000000A0  // sll x10, x1, x1
0011D5B3 0B 0091A280  // srl x11, x3, x1
00158613 0C 0091A281  // addi x12, x11, 1
00C606B3 0D 01234502  // add x13, x12, x12
40168733 0E 012344FD  // sub x14, x13, x1
FFF74793 0F FEDCBB02  // xori x15, x14, -1
00479813 10 EDCBB020  // slli x16, x15, 4
00708013 00 0000000C  // addi x0, x1, 7
010008B3 11 EDCBB020  // add x17, x0, x16
FFC12913 12 00000000  // slti x18, x2, -4
00000000 00 00000000  // nop
00190993 13 00000001  // addi x19, x18, 1
00198993 13 00000002  // addi x19, x19, 1
00198993 13 00000003  // addi x19, x19, 1
01398A33 14 00000006  // add x20, x19, x19

//--- filelist.f
+incdir+.
isa_pkg.sv
core_pkg.sv
inst_decoder.sv
rename_regfile.sv
reorder_buffer.sv
alu_station.sv
ooo_core_top.sv
tb_ooo_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_ooo_core
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 10;
  localparam int NUM_LINES       = 25; // data lines in ooo_testdata.txt
  localparam int CYCLES_PER_LINE = 20;
  localparam int TIMEOUT_NS      = (RESET_CYCLES + NUM_LINES * CYCLES_PER_LINE) * CLK_PERIOD;

  logic clk_100mhz = 1'b0;
  logic sys_rst;
  logic i_inst_valid;
  isa_pkg::inst_word_u i_inst;
  logic o_inst_ready;
  logic o_commit_valid;
  core_pkg::reg_idx_t o_commit_rd;
  core_pkg::word_t o_commit_value;

  logic [31:0] test_data [3*NUM_LINES]; // word, rd, value per line
  core_pkg::reg_idx_t exp_rd [$];
  core_pkg::word_t exp_value [$];
  int exp_line [$];
  int expected_total;
  int commit_count;
  int stall_cycles;

  ooo_core_top ooo_core_top_inst (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .i_inst_valid(i_inst_valid),
    .i_inst(i_inst),
    .o_inst_ready(o_inst_ready),
    .o_commit_valid(o_commit_valid),
    .o_commit_rd(o_commit_rd),
    .o_commit_value(o_commit_value)
  );

  always #(CLK_PERIOD/2) clk_100mhz = ~clk_100mhz;

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_rd(input string name, input core_pkg::reg_idx_t expected,
                          input core_pkg::reg_idx_t actual);
    if (actual !== expected) begin
      $display("Error: %s rd expected %0d actual %0d", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_value(input string name, input core_pkg::word_t expected,
                             input core_pkg::word_t actual);
    if (actual !== expected) begin
      $display("Error: %s value expected %08h actual %08h", name, expected, actual);
      abort_run();
    end
  endtask

  // valid low for n cycles, junk on the bus meanwhile
  task automatic idle_cycles(input int n);
    i_inst_valid = 1'b0;
    repeat (n) begin
      i_inst = $urandom();
      @(posedge clk_100mhz);
      #1;
    end
  endtask

  // hold the word until the core takes it
  task automatic send_inst(input logic [31:0] word);
    logic accepted;
    accepted     = 1'b0;
    i_inst_valid = 1'b1;
    i_inst       = word;
    while (!accepted) begin
      @(negedge clk_100mhz);
      accepted = o_inst_ready; // ready comes from registered full flags
      if (!accepted) begin
        stall_cycles++;
      end
      @(posedge clk_100mhz);
      #1;
    end
    i_inst_valid = 1'b0;
    i_inst       = '0;
  endtask

  // one check per retired instruction, in program order
  always @(negedge clk_100mhz) begin
    string name;
    if (!sys_rst && o_commit_valid) begin
      if (exp_rd.size() == 0) begin
        $display("commit to x%0d with no instruction left to retire", o_commit_rd);
        abort_run();
      end else begin
        name = $sformatf("line %0d", exp_line.pop_front());
        check_rd(name, exp_rd.pop_front(), o_commit_rd);
        check_value(name, exp_value.pop_front(), o_commit_value);
        commit_count++;
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout after %0d ns with %0d of %0d commits seen",
             TIMEOUT_NS, commit_count, expected_total);
    abort_run();
  end

  initial begin
    int gap;
    void'($urandom(50)); // one seed for the whole run
    sys_rst        = 1'b1;
    i_inst_valid   = 1'b0;
    i_inst         = '0;
    commit_count   = 0;
    stall_cycles   = 0;
    $readmemh("ooo_testdata.txt", test_data);
    for (int k = 0; k < NUM_LINES; k++) begin
      if (test_data[3*k] != 32'h0) begin // zero word is a nop
        exp_line.push_back(k + 1);
        exp_rd.push_back(core_pkg::reg_idx_t'(test_data[3*k+1]));
        exp_value.push_back(test_data[3*k+2]);
      end
    end
    expected_total = exp_rd.size();

    repeat (RESET_CYCLES) @(posedge clk_100mhz);
    #1;
    sys_rst = 1'b0;

    // nothing issued yet
    repeat (3) begin
      @(negedge clk_100mhz);
      if (o_commit_valid !== 1'b0) begin
        $display("commit valid is high after reset with nothing issued");
        abort_run();
      end
      if (o_inst_ready !== 1'b1) begin
        $display("core is not ready after reset");
        abort_run();
      end
    end
    @(posedge clk_100mhz);
    #1;

    for (int k = 0; k < NUM_LINES; k++) begin
      // back to back until the core pushes back once, then random gaps
      if (stall_cycles == 0) begin
        gap = 0;
      end else begin
        gap = ($urandom % 4 == 0) ? int'($urandom % 3) + 1 : 0;
      end
      idle_cycles(gap);
      send_inst(test_data[3*k]);
    end

    while (exp_rd.size() != 0) begin
      @(posedge clk_100mhz);
    end
    repeat (5) @(posedge clk_100mhz); // room for a stray commit
    $display("%0d commits, %0d cycles held by back-pressure", commit_count, stall_cycles);
    if (stall_cycles > 0 && o_inst_ready === 1'b1) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("core never pushed back or is not ready when drained, ready %b, %0d held cycles",
               o_inst_ready, stall_cycles);
      abort_run();
    end
  end

endmodule

//--- ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top (
  input  logic clk_100mhz,
  input  logic sys_rst,
  input  logic i_inst_valid,
  input  isa_pkg::inst_word_u i_inst,
  output logic o_inst_ready,
  output logic o_commit_valid,
  output core_pkg::reg_idx_t o_commit_rd,
  output core_pkg::word_t o_commit_value
);

  isa_pkg::inst_class_e dec_class;
  isa_pkg::alu_func_e dec_func;
  core_pkg::reg_idx_t dec_rs1, dec_rs2, dec_rd;
  core_pkg::word_t dec_imm;

  core_pkg::word_t rf_val1, rf_val2;
  logic rf_pend1, rf_pend2;
  core_pkg::rob_tag_t rf_tag1, rf_tag2;

  logic rob_full, rs_full;
  core_pkg::rob_tag_t issue_tag;
  logic fwd_done1, fwd_done2;
  core_pkg::word_t fwd_val1, fwd_val2;
  logic commit;
  core_pkg::reg_idx_t commit_rd;
  core_pkg::rob_tag_t commit_tag;
  core_pkg::word_t commit_value;

  logic cdb_valid;
  core_pkg::rob_tag_t cdb_tag;
  core_pkg::word_t cdb_value;

  logic take, issue;
  core_pkg::word_t vi, vj;
  logic ri, rj;

  assign o_inst_ready = !rob_full && !rs_full;
  assign take  = i_inst_valid && o_inst_ready;
  assign issue = take && (dec_class != isa_pkg::CLASS_NOP); // nops just drain

  // operand source: regfile, finished rob entry, or the bus this cycle
  always_comb begin
    vi = rf_val1;
    ri = 1'b1;
    if (rf_pend1) begin
      if (fwd_done1) begin
        vi = fwd_val1;
      end else if (cdb_valid && cdb_tag == rf_tag1) begin
        vi = cdb_value;
      end else begin
        ri = 1'b0;
      end
    end
    vj = rf_val2;
    rj = 1'b1;
    if (dec_class != isa_pkg::CLASS_OP) begin
      vj = dec_imm; // opimm and lui
    end else if (rf_pend2) begin
      if (fwd_done2) begin
        vj = fwd_val2;
      end else if (cdb_valid && cdb_tag == rf_tag2) begin
        vj = cdb_value;
      end else begin
        rj = 1'b0;
      end
    end
  end

  inst_decoder inst_decoder_inst (
    .i_inst(i_inst), .o_class(dec_class), .o_alu_func(dec_func),
    .o_rs1(dec_rs1), .o_rs2(dec_rs2), .o_rd(dec_rd), .o_imm(dec_imm)
  );

  rename_regfile rename_regfile_inst (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_rs1(dec_rs1), .i_rs2(dec_rs2),
    .i_issue(issue), .i_issue_rd(dec_rd), .i_issue_tag(issue_tag),
    .i_commit(commit), .i_commit_rd(commit_rd), .i_commit_tag(commit_tag),
    .i_commit_value(commit_value),
    .o_val1(rf_val1), .o_val2(rf_val2), .o_pend1(rf_pend1), .o_pend2(rf_pend2),
    .o_tag1(rf_tag1), .o_tag2(rf_tag2)
  );

  reorder_buffer reorder_buffer_inst (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_alloc(issue), .i_alloc_rd(dec_rd), .o_alloc_tag(issue_tag), .o_full(rob_full),
    .i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag), .i_cdb_value(cdb_value),
    .i_fwd_tag1(rf_tag1), .i_fwd_tag2(rf_tag2),
    .o_fwd_done1(fwd_done1), .o_fwd_done2(fwd_done2),
    .o_fwd_val1(fwd_val1), .o_fwd_val2(fwd_val2),
    .o_commit(commit), .o_commit_rd(commit_rd), .o_commit_tag(commit_tag),
    .o_commit_value(commit_value)
  );

  alu_station alu_station_inst (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_issue(issue), .i_func(dec_func), .i_tag(issue_tag),
    .i_vi(vi), .i_vj(vj), .i_qi(rf_tag1), .i_qj(rf_tag2), .i_ri(ri), .i_rj(rj),
    .o_full(rs_full),
    .o_cdb_valid(cdb_valid), .o_cdb_tag(cdb_tag), .o_cdb_value(cdb_value)
  );

  assign o_commit_valid = commit;
  assign o_commit_rd    = commit_rd;
  assign o_commit_value = commit_value;

endmodule

//--- alu_station.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module alu_station (
  input  logic clk_100mhz,
  input  logic sys_rst,
  input  logic i_issue,
  input  isa_pkg::alu_func_e i_func,
  input  core_pkg::rob_tag_t i_tag,
  input  core_pkg::word_t i_vi,
  input  core_pkg::word_t i_vj,
  input  core_pkg::rob_tag_t i_qi,
  input  core_pkg::rob_tag_t i_qj,
  input  logic i_ri,
  input  logic i_rj,
  output logic o_full,
  output logic o_cdb_valid,
  output core_pkg::rob_tag_t o_cdb_tag,
  output core_pkg::word_t o_cdb_value
);

  localparam int IDX_W = $clog2(`RS_DEPTH);

  logic [`RS_DEPTH-1:0] ent_valid;
  logic [`RS_DEPTH-1:0] ent_ri;
  logic [`RS_DEPTH-1:0] ent_rj;
  isa_pkg::alu_func_e ent_func [`RS_DEPTH];
  core_pkg::rob_tag_t ent_tag [`RS_DEPTH];
  core_pkg::rob_tag_t ent_qi [`RS_DEPTH];
  core_pkg::rob_tag_t ent_qj [`RS_DEPTH];
  core_pkg::word_t ent_vi [`RS_DEPTH];
  core_pkg::word_t ent_vj [`RS_DEPTH];
  logic [IDX_W-1:0] ent_age [`RS_DEPTH]; // 0 is oldest

  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] disp_idx;
  logic disp_valid;
  logic [IDX_W:0] used_cnt;
  logic [IDX_W-1:0] new_age;
  core_pkg::word_t op_a;
  core_pkg::word_t op_b;
  core_pkg::word_t alu_res;

  assign o_full = &ent_valid;

  always_comb begin
    free_idx   = '0;
    disp_idx   = '0;
    disp_valid = 1'b0;
    used_cnt   = '0;
    for (int k = `RS_DEPTH - 1; k >= 0; k--) begin
      if (!ent_valid[k]) begin
        free_idx = IDX_W'(k); // lowest free slot
      end
    end
    for (int k = 0; k < `RS_DEPTH; k++) begin
      used_cnt = used_cnt + (IDX_W+1)'(ent_valid[k]);
      // oldest entry with both operands in hand
      if (ent_valid[k] && ent_ri[k] && ent_rj[k] &&
          (!disp_valid || ent_age[k] < ent_age[disp_idx])) begin
        disp_valid = 1'b1;
        disp_idx   = IDX_W'(k);
      end
    end
    new_age = IDX_W'(used_cnt - (IDX_W+1)'(disp_valid));
  end

  always_comb begin
    op_a = ent_vi[disp_idx];
    op_b = ent_vj[disp_idx];
    case (ent_func[disp_idx])
      isa_pkg::ALU_SUB: alu_res = op_a - op_b;
      isa_pkg::ALU_AND: alu_res = op_a & op_b;
      isa_pkg::ALU_OR:  alu_res = op_a | op_b;
      isa_pkg::ALU_XOR: alu_res = op_a ^ op_b;
      isa_pkg::ALU_SLT: alu_res = core_pkg::word_t'($signed(op_a) < $signed(op_b));
      isa_pkg::ALU_SLL: alu_res = op_a << op_b[4:0];
      isa_pkg::ALU_SRL: alu_res = op_a >> op_b[4:0];
      default:          alu_res = op_a + op_b;
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      ent_valid   <= '0;
      o_cdb_valid <= 1'b0;
    end else begin
      for (int k = 0; k < `RS_DEPTH; k++) begin
        if (ent_valid[k]) begin
          // wakeup from the bus, our own results included
          if (o_cdb_valid && !ent_ri[k] && ent_qi[k] == o_cdb_tag) begin
            ent_vi[k] <= o_cdb_value;
            ent_ri[k] <= 1'b1;
          end
          if (o_cdb_valid && !ent_rj[k] && ent_qj[k] == o_cdb_tag) begin
            ent_vj[k] <= o_cdb_value;
            ent_rj[k] <= 1'b1;
          end
          if (disp_valid && ent_age[k] > ent_age[disp_idx]) begin
            ent_age[k] <= ent_age[k] - 1'b1;
          end
        end
      end
      if (disp_valid) begin
        ent_valid[disp_idx] <= 1'b0;
      end
      if (i_issue) begin
        ent_valid[free_idx] <= 1'b1;
        ent_func[free_idx]  <= i_func;
        ent_tag[free_idx]   <= i_tag;
        ent_vi[free_idx]    <= i_vi;
        ent_vj[free_idx]    <= i_vj;
        ent_qi[free_idx]    <= i_qi;
        ent_qj[free_idx]    <= i_qj;
        ent_ri[free_idx]    <= i_ri;
        ent_rj[free_idx]    <= i_rj;
        ent_age[free_idx]   <= new_age; // youngest
      end
      o_cdb_valid <= disp_valid;
    end
  end

  // registered alu stage, its output is the bus
  always_ff @(posedge clk_100mhz) begin
    if (disp_valid) begin
      o_cdb_tag   <= ent_tag[disp_idx];
      o_cdb_value <= alu_res;
    end
  end

endmodule

//--- reorder_buffer.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module reorder_buffer (
  input  logic clk_100mhz,
  input  logic sys_rst,
  input  logic i_alloc,
  input  core_pkg::reg_idx_t i_alloc_rd,
  output core_pkg::rob_tag_t o_alloc_tag,
  output logic o_full,
  input  logic i_cdb_valid,
  input  core_pkg::rob_tag_t i_cdb_tag,
  input  core_pkg::word_t i_cdb_value,
  input  core_pkg::rob_tag_t i_fwd_tag1,
  input  core_pkg::rob_tag_t i_fwd_tag2,
  output logic o_fwd_done1,
  output logic o_fwd_done2,
  output core_pkg::word_t o_fwd_val1,
  output core_pkg::word_t o_fwd_val2,
  output logic o_commit,
  output core_pkg::reg_idx_t o_commit_rd,
  output core_pkg::rob_tag_t o_commit_tag,
  output core_pkg::word_t o_commit_value
);

  localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

  logic [`ROB_DEPTH-1:0] ent_valid;
  logic [`ROB_DEPTH-1:0] ent_done;
  core_pkg::reg_idx_t ent_rd [`ROB_DEPTH];
  core_pkg::word_t ent_value [`ROB_DEPTH];

  core_pkg::rob_tag_t head;
  core_pkg::rob_tag_t tail;
  logic [CNT_W-1:0] count;

  assign o_full      = (count == CNT_W'(`ROB_DEPTH));
  assign o_alloc_tag = tail;

  // finished entries feed operands at issue
  assign o_fwd_done1 = ent_valid[i_fwd_tag1] && ent_done[i_fwd_tag1];
  assign o_fwd_done2 = ent_valid[i_fwd_tag2] && ent_done[i_fwd_tag2];
  assign o_fwd_val1  = ent_value[i_fwd_tag1];
  assign o_fwd_val2  = ent_value[i_fwd_tag2];

  // head retires as soon as its result is in
  assign o_commit       = ent_valid[head] && ent_done[head];
  assign o_commit_rd    = ent_rd[head];
  assign o_commit_tag   = head;
  assign o_commit_value = ent_value[head];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      ent_valid <= '0;
      ent_done  <= '0;
      head      <= '0;
      tail      <= '0;
      count     <= '0;
    end else begin
      if (i_cdb_valid) begin
        ent_done[i_cdb_tag] <= 1'b1;
      end
      if (i_alloc) begin
        ent_valid[tail] <= 1'b1;
        ent_done[tail]  <= 1'b0;
        tail            <= tail + 1'b1; // wraps at ROB_DEPTH
      end
      if (o_commit) begin
        ent_valid[head] <= 1'b0;
        head            <= head + 1'b1;
      end
      count <= count + CNT_W'(i_alloc) - CNT_W'(o_commit);
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_alloc) begin
      ent_rd[tail] <= i_alloc_rd;
    end
    if (i_cdb_valid) begin
      ent_value[i_cdb_tag] <= i_cdb_value;
    end
  end

endmodule

//--- rename_regfile.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module rename_regfile (
  input  logic clk_100mhz,
  input  logic sys_rst,
  input  core_pkg::reg_idx_t i_rs1,
  input  core_pkg::reg_idx_t i_rs2,
  input  logic i_issue,
  input  core_pkg::reg_idx_t i_issue_rd,
  input  core_pkg::rob_tag_t i_issue_tag,
  input  logic i_commit,
  input  core_pkg::reg_idx_t i_commit_rd,
  input  core_pkg::rob_tag_t i_commit_tag,
  input  core_pkg::word_t i_commit_value,
  output core_pkg::word_t o_val1,
  output core_pkg::word_t o_val2,
  output logic o_pend1,
  output logic o_pend2,
  output core_pkg::rob_tag_t o_tag1,
  output core_pkg::rob_tag_t o_tag2
);

  core_pkg::word_t regs [`NUM_REGS];
  core_pkg::rob_tag_t pend_tag [`NUM_REGS]; // youngest producer in flight
  logic [`NUM_REGS-1:0] pend;

  logic issue_wr;
  logic commit_wr;

  assign issue_wr  = i_issue && (i_issue_rd != '0);
  assign commit_wr = i_commit && (i_commit_rd != '0);

  // x0 never gets written or marked, so it reads as zero and ready
  assign o_val1  = regs[i_rs1];
  assign o_val2  = regs[i_rs2];
  assign o_pend1 = pend[i_rs1];
  assign o_pend2 = pend[i_rs2];
  assign o_tag1  = pend_tag[i_rs1];
  assign o_tag2  = pend_tag[i_rs2];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      pend <= '0;
      for (int k = 0; k < `NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else begin
      if (commit_wr) begin
        regs[i_commit_rd] <= i_commit_value;
        // a younger writer may still be outstanding
        if (pend_tag[i_commit_rd] == i_commit_tag) begin
          pend[i_commit_rd] <= 1'b0;
        end
      end
      if (issue_wr) begin
        pend[i_issue_rd] <= 1'b1; // issue wins over a same-cycle clear
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (issue_wr) begin
      pend_tag[i_issue_rd] <= i_issue_tag;
    end
  end

endmodule

//--- inst_decoder.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module inst_decoder (
  input  isa_pkg::inst_word_u i_inst,
  output isa_pkg::inst_class_e o_class,
  output isa_pkg::alu_func_e o_alu_func,
  output core_pkg::reg_idx_t o_rs1,
  output core_pkg::reg_idx_t o_rs2,
  output core_pkg::reg_idx_t o_rd,
  output core_pkg::word_t o_imm
);

  // funct3 to alu op, i_sub only matters for funct3 000
  function automatic isa_pkg::alu_func_e map_funct3(input logic [2:0] i_f3, input logic i_sub);
    case (i_f3)
      3'b000:  return i_sub ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
      3'b001:  return isa_pkg::ALU_SLL;
      3'b010:  return isa_pkg::ALU_SLT;
      3'b100:  return isa_pkg::ALU_XOR;
      3'b101:  return isa_pkg::ALU_SRL;
      3'b110:  return isa_pkg::ALU_OR;
      3'b111:  return isa_pkg::ALU_AND;
      default: return isa_pkg::ALU_ADD; // sltu not supported
    endcase
  endfunction

  always_comb begin
    o_class    = isa_pkg::CLASS_NOP;
    o_alu_func = isa_pkg::ALU_ADD;
    o_rs1      = i_inst.r.rs1;
    o_rs2      = i_inst.r.rs2;
    o_rd       = i_inst.r.rd;
    o_imm      = {{(`XLEN-12){i_inst.i.imm12[11]}}, i_inst.i.imm12}; // sign extended imm12
    case (i_inst.r.opcode)
      isa_pkg::OPC_OP: begin
        o_class    = isa_pkg::CLASS_OP;
        o_alu_func = map_funct3(i_inst.r.funct3, i_inst.r.funct7[5]);
      end
      isa_pkg::OPC_OPIMM: begin
        o_class    = isa_pkg::CLASS_OPIMM;
        o_alu_func = map_funct3(i_inst.i.funct3, 1'b0); // no subi
      end
      isa_pkg::OPC_LUI: begin
        // upper 20 bits sit where imm12, rs1 and funct3 live in the i view
        o_class = isa_pkg::CLASS_LUI;
        o_rs1   = '0;
        o_imm   = {i_inst.i.imm12, i_inst.i.rs1, i_inst.i.funct3, 12'b0};
      end
      default: begin
        o_rd = '0; // dropped at issue anyway
      end
    endcase
  end

endmodule

//--- core_pkg.sv
package core_pkg;

`include "core_macros.svh"

  // index of a reorder buffer entry, doubles as the rename tag
  typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

  // architectural register number
  typedef logic [4:0] reg_idx_t;

  typedef logic [`XLEN-1:0] word_t;

endpackage

//--- isa_pkg.sv
package isa_pkg;

  // 7-bit major opcodes
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;

  typedef enum logic [1:0] {
    CLASS_NOP   = 2'd0,
    CLASS_OP    = 2'd1,
    CLASS_OPIMM = 2'd2,
    CLASS_LUI   = 2'd3
  } inst_class_e;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLT = 4'd5,
    ALU_SLL = 4'd6,
    ALU_SRL = 4'd7
  } alu_func_e;

  // register-register view
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_format_t;

  // immediate view, also covers the upper immediate of lui
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_format_t;

  typedef union packed {
    r_format_t r;
    i_format_t i;
  } inst_word_u;

endpackage

//--- core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and instruction word width
`define XLEN 32

// architectural registers x0..x31
`define NUM_REGS 32

// reorder buffer entries, power of two so the pointers wrap on their own
`define ROB_DEPTH 8

// alu reservation station entries
`define RS_DEPTH 4

`endif
